// File: source/ssb_pkg.sv
`default_nettype none

package ssb_pkg;

    // ************************************************************
    // sample and arithmetic types.
    // ************************************************************

    // one complex sample, signed re in [15:8], signed im in [7:0].
    typedef logic [15:0] sample_t;

    // signed correlation sum, also wide enough for |re| + |im|.
    typedef logic signed [17:0] corr_t;

    // symbol index inside the ssb, 0 is the pss.
    typedef logic [1:0] sym_idx_t;

    // ************************************************************
    // extractor control.
    // ************************************************************

    typedef enum logic [1:0] {
        SEARCH,
        CPREFIX,
        BODY
    } ext_state_e;

    // last symbol cut out after a pss.
    localparam sym_idx_t SSB_LAST_SYM = 2'd3;

endpackage

`default_nettype wire

// File: source/smp_if.sv
`timescale 1ns/1ps
`default_nettype none

// tagged sample stream, valid/ready handshake.
interface smp_if;

    ssb_pkg::sample_t data;
    logic             peak;
    logic             valid;
    logic             ready;

    // producer side.
    modport src (
        output data,
        output peak,
        output valid,
        input  ready
    );

    // consumer side.
    modport dst (
        input  data,
        input  peak,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// File: source/pss_correlator.sv
`timescale 1ns/1ps
`default_nettype none

module pss_correlator #(
    parameter int                 PSS_LEN          = 16,
    parameter logic [PSS_LEN-1:0] PSS_TAPS         = '1,
    parameter int                 DETECT_THRESHOLD = 2048
) (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire ssb_pkg::sample_t smp_i,
    input  wire logic             smp_valid_i,
    output ssb_pkg::sample_t      smp_o,
    output logic                  peak_o,
    output logic                  smp_valid_o
);

    // window index 0 holds the oldest sample.
    ssb_pkg::sample_t win_q [PSS_LEN];
    ssb_pkg::sample_t win_d [PSS_LEN];

    ssb_pkg::corr_t   sum_re_d;
    ssb_pkg::corr_t   sum_im_d;
    ssb_pkg::corr_t   sum_re_q;
    ssb_pkg::corr_t   sum_im_q;
    ssb_pkg::sample_t s1_smp_q;
    logic             s1_valid_q;

    ssb_pkg::corr_t   abs_re;
    ssb_pkg::corr_t   abs_im;
    ssb_pkg::corr_t   metric_d;

    // ************************************************************
    // stage 1, window shift and tap-signed sums.
    // ************************************************************

    always_comb begin
        for (int i = 0; i < PSS_LEN - 1; i++) begin
            win_d[i] = win_q[i + 1];
        end
        win_d[PSS_LEN-1] = smp_i;
    end

    // sums cover the window including the incoming sample.
    always_comb begin
        ssb_pkg::corr_t re_v;
        ssb_pkg::corr_t im_v;
        sum_re_d = '0;
        sum_im_d = '0;
        for (int i = 0; i < PSS_LEN; i++) begin
            re_v = ssb_pkg::corr_t'($signed(win_d[i][15:8]));
            im_v = ssb_pkg::corr_t'($signed(win_d[i][7:0]));
            if (PSS_TAPS[i]) begin
                sum_re_d = sum_re_d + re_v;
                sum_im_d = sum_im_d + im_v;
            end else begin
                sum_re_d = sum_re_d - re_v;
                sum_im_d = sum_im_d - im_v;
            end
        end
    end

    // window starts from zeros so early sums are defined.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < PSS_LEN; i++) begin
                win_q[i] <= '0;
            end
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= smp_valid_i;
            if (smp_valid_i) begin
                win_q <= win_d;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (smp_valid_i) begin
            sum_re_q <= sum_re_d;
            sum_im_q <= sum_im_d;
            s1_smp_q <= smp_i;
        end
    end

    // ************************************************************
    // stage 2, metric and threshold.
    // ************************************************************

    assign abs_re   = (sum_re_q < 0) ? -sum_re_q : sum_re_q;
    assign abs_im   = (sum_im_q < 0) ? -sum_im_q : sum_im_q;
    assign metric_d = abs_re + abs_im;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            smp_valid_o <= 1'b0;
            peak_o      <= 1'b0;
        end else begin
            smp_valid_o <= s1_valid_q;
            peak_o      <= s1_valid_q && (metric_d >= DETECT_THRESHOLD);
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid_q) begin
            smp_o <= s1_smp_q;
        end
    end

    // the tag must ride on a real sample.
    peak_needs_valid: assert property (
        @(posedge clk_i) disable iff (rst_i) peak_o |-> smp_valid_o
    );

endmodule

`default_nettype wire

// File: source/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire ssb_pkg::sample_t wr_data_i,
    input  wire logic             wr_peak_i,
    input  wire logic             wr_valid_i,
    smp_if.src                    rd,
    output logic                  overflow_o
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] FULL_CNT = (AW + 1)'(FIFO_DEPTH);

    ssb_pkg::sample_t mem_data [FIFO_DEPTH];
    logic             mem_peak [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic          full;
    logic          push;
    logic          pop;

    assign full = (count_q == FULL_CNT);
    assign push = wr_valid_i && !full;
    assign pop  = rd.valid && rd.ready;

    // head is shown without a read request.
    assign rd.data  = mem_data[rd_ptr_q];
    assign rd.peak  = mem_peak[rd_ptr_q];
    assign rd.valid = (count_q != '0);

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_data[wr_ptr_q] <= wr_data_i;
            mem_peak[wr_ptr_q] <= wr_peak_i;
        end
    end

    // pointers wrap naturally, depth is a power of two.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
            // sticky until reset.
            if (wr_valid_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    count_in_range: assert property (
        @(posedge clk_i) disable iff (rst_i) count_q <= FULL_CNT
    );

endmodule

`default_nettype wire

// File: source/ssb_extractor.sv
`timescale 1ns/1ps
`default_nettype none

module ssb_extractor #(
    parameter int FFT_LEN = 16,
    parameter int CP_LEN  = 4
) (
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    smp_if.dst               in,
    output ssb_pkg::sample_t data_o,
    output logic             valid_o,
    input  wire logic        ready_i,
    output logic             last_o,
    output ssb_pkg::sym_idx_t sym_o,
    output logic             pbch_valid_o,
    output logic             sss_valid_o
);

    localparam int CNT_W = $clog2((FFT_LEN > CP_LEN) ? FFT_LEN : CP_LEN);
    localparam logic [CNT_W-1:0] CP_END   = CNT_W'(CP_LEN - 1);
    localparam logic [CNT_W-1:0] BODY_END = CNT_W'(FFT_LEN - 1);

    // nr order, sss sits between the two pbch symbols.
    localparam ssb_pkg::sym_idx_t SSS_SYM = 2'd2;

    ssb_pkg::ext_state_e state_q;
    logic [CNT_W-1:0]    cnt_q;
    ssb_pkg::sym_idx_t   sym_q;
    logic                pop;
    logic                take;
    logic                body_end;

    // prefix and search samples are always drained.
    assign in.ready = (state_q == ssb_pkg::BODY) ? (!valid_o || ready_i) : 1'b1;
    assign pop      = in.valid && in.ready;
    assign take     = pop && (state_q == ssb_pkg::BODY);
    assign body_end = (cnt_q == BODY_END);

    // ************************************************************
    // symbol sequencing.
    // ************************************************************

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ssb_pkg::SEARCH;
            cnt_q   <= '0;
            sym_q   <= '0;
        end else if (pop) begin
            case (state_q)
                ssb_pkg::SEARCH: begin
                    if (in.peak) begin
                        state_q <= ssb_pkg::CPREFIX;
                        cnt_q   <= '0;
                        sym_q   <= 2'd1;
                    end
                end
                ssb_pkg::CPREFIX: begin
                    if (cnt_q == CP_END) begin
                        state_q <= ssb_pkg::BODY;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ssb_pkg::BODY: begin
                    if (body_end) begin
                        cnt_q <= '0;
                        if (sym_q == ssb_pkg::SSB_LAST_SYM) begin
                            state_q <= ssb_pkg::SEARCH;
                        end else begin
                            sym_q   <= sym_q + 1'b1;
                            state_q <= ssb_pkg::CPREFIX;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= ssb_pkg::SEARCH;
                end
            endcase
        end
    end

    // ************************************************************
    // output stage, refills in the cycle it drains.
    // ************************************************************

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o      <= 1'b0;
            last_o       <= 1'b0;
            pbch_valid_o <= 1'b0;
            sss_valid_o  <= 1'b0;
        end else if (take) begin
            valid_o      <= 1'b1;
            last_o       <= body_end;
            pbch_valid_o <= (sym_q != SSS_SYM);
            sss_valid_o  <= (sym_q == SSS_SYM);
        end else if (ready_i) begin
            valid_o      <= 1'b0;
            last_o       <= 1'b0;
            pbch_valid_o <= 1'b0;
            sss_valid_o  <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            data_o <= in.data;
            sym_o  <= sym_q;
        end
    end

    last_with_valid: assert property (
        @(posedge clk_i) disable iff (rst_i) last_o |-> valid_o
    );

endmodule

`default_nettype wire

// File: source/ssb_sync_top.sv
`timescale 1ns/1ps
`default_nettype none

module ssb_sync_top #(
    parameter int                 PSS_LEN          = 16,
    parameter logic [PSS_LEN-1:0] PSS_TAPS         = 16'b0110_1011_0001_1110,
    parameter int                 DETECT_THRESHOLD = 2048,
    parameter int                 FFT_LEN          = 16,
    parameter int                 CP_LEN           = 4,
    parameter int                 FIFO_DEPTH       = 16
) (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire ssb_pkg::sample_t  s_axis_in_tdata_i,
    input  wire logic              s_axis_in_tvalid_i,
    input  wire logic              m_axis_out_tready_i,
    output ssb_pkg::sample_t       m_axis_out_tdata_o,
    output logic                   m_axis_out_tvalid_o,
    output logic                   m_axis_out_tlast_o,
    output ssb_pkg::sym_idx_t      m_axis_out_tuser_o,
    output logic                   pbch_valid_o,
    output logic                   sss_valid_o,
    output logic                   overflow_o
);

    // correlator output, cannot be stalled.
    ssb_pkg::sample_t corr_smp;
    logic             corr_peak;
    logic             corr_valid;

    smp_if fifo_rd ();

    pss_correlator #(
        .PSS_LEN          (PSS_LEN),
        .PSS_TAPS         (PSS_TAPS),
        .DETECT_THRESHOLD (DETECT_THRESHOLD)
    ) pss_correlator_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .smp_i       (s_axis_in_tdata_i),
        .smp_valid_i (s_axis_in_tvalid_i),
        .smp_o       (corr_smp),
        .peak_o      (corr_peak),
        .smp_valid_o (corr_valid)
    );

    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sample_fifo_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wr_data_i  (corr_smp),
        .wr_peak_i  (corr_peak),
        .wr_valid_i (corr_valid),
        .rd         (fifo_rd.src),
        .overflow_o (overflow_o)
    );

    ssb_extractor #(
        .FFT_LEN (FFT_LEN),
        .CP_LEN  (CP_LEN)
    ) ssb_extractor_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .in           (fifo_rd.dst),
        .data_o       (m_axis_out_tdata_o),
        .valid_o      (m_axis_out_tvalid_o),
        .ready_i      (m_axis_out_tready_i),
        .last_o       (m_axis_out_tlast_o),
        .sym_o        (m_axis_out_tuser_o),
        .pbch_valid_o (pbch_valid_o),
        .sss_valid_o  (sss_valid_o)
    );

endmodule

`default_nettype wire

// File: tests/tb_ssb_model.svh
`ifndef TB_SSB_MODEL_SVH
`define TB_SSB_MODEL_SVH

// ************************************************************
// reference model of the correlator and the extractor.
// ************************************************************

typedef struct packed {
    ssb_pkg::sample_t  data;
    logic              last;
    ssb_pkg::sym_idx_t sym;
    logic              pbch;
    logic              sss;
} beat_t;

localparam int M_SEARCH = 0;
localparam int M_PREFIX = 1;
localparam int M_BODY   = 2;

beat_t            exp_q[$];
ssb_pkg::sample_t mdl_win [PSS_LEN];
int               mdl_state;
int               mdl_cnt;
int               mdl_sym;

function automatic int abs_int(input int v);
    return (v < 0) ? -v : v;
endfunction

task automatic model_reset();
    for (int i = 0; i < PSS_LEN; i++) begin
        mdl_win[i] = '0;
    end
    mdl_state = M_SEARCH;
    mdl_cnt   = 0;
    mdl_sym   = 0;
    exp_q.delete();
endtask

// one accepted input sample, oldest window slot first.
task automatic model_step(input ssb_pkg::sample_t s);
    int    re_sum;
    int    im_sum;
    int    re;
    int    im;
    logic  peak;
    beat_t b;
    for (int i = 0; i < PSS_LEN - 1; i++) begin
        mdl_win[i] = mdl_win[i + 1];
    end
    mdl_win[PSS_LEN-1] = s;
    re_sum = 0;
    im_sum = 0;
    for (int i = 0; i < PSS_LEN; i++) begin
        re = $signed(mdl_win[i][15:8]);
        im = $signed(mdl_win[i][7:0]);
        if (PSS_TAPS[i]) begin
            re_sum += re;
            im_sum += im;
        end else begin
            re_sum -= re;
            im_sum -= im;
        end
    end
    peak = (abs_int(re_sum) + abs_int(im_sum)) >= DETECT_THRESHOLD;
    case (mdl_state)
        M_SEARCH: begin
            if (peak) begin
                mdl_state = M_PREFIX;
                mdl_cnt   = 0;
                mdl_sym   = 1;
            end
        end
        M_PREFIX: begin
            mdl_cnt++;
            if (mdl_cnt == CP_LEN) begin
                mdl_state = M_BODY;
                mdl_cnt   = 0;
            end
        end
        default: begin
            b.data = s;
            b.last = (mdl_cnt == FFT_LEN - 1);
            b.sym  = 2'(mdl_sym);
            b.pbch = (mdl_sym == 1) || (mdl_sym == 3);
            b.sss  = (mdl_sym == 2);
            exp_q.push_back(b);
            mdl_cnt++;
            if (mdl_cnt == FFT_LEN) begin
                mdl_cnt = 0;
                if (mdl_sym == 3) begin
                    mdl_state = M_SEARCH;
                end else begin
                    mdl_sym++;
                    mdl_state = M_PREFIX;
                end
            end
        end
    endcase
endtask

`endif

// File: tests/tb_ssb_sync.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ssb_sync;

    localparam int                 PSS_LEN          = 16;
    localparam logic [PSS_LEN-1:0] PSS_TAPS         = 16'b0110_1011_0001_1110;
    localparam int                 DETECT_THRESHOLD = 2048;
    localparam int                 FFT_LEN          = 16;
    localparam int                 CP_LEN           = 4;
    localparam int                 FIFO_DEPTH       = 16;
    localparam logic [31:0]        SEED             = 32'h5fd846ab;
    localparam int                 PSS_AMP          = 100;
    localparam int                 FLUSH_CYCLES     = 8;

    // sample budget of all tests, gaps and stalls fit in the factor.
    localparam int SSB_SAMPLES    = PSS_LEN + 3 * (CP_LEN + FFT_LEN);
    localparam int STIM_SAMPLES   = (20 + SSB_SAMPLES) + 200 + 2 * (10 + SSB_SAMPLES)
                                    + (2 * SSB_SAMPLES + 10) + (5 + PSS_LEN + 3 * FIFO_DEPTH);
    localparam int TIMEOUT_CYCLES = STIM_SAMPLES * 4 + 500;

    logic              clk_i;
    logic              rst_i;
    ssb_pkg::sample_t  in_tdata;
    logic              in_tvalid;
    logic              out_tready;
    ssb_pkg::sample_t  out_tdata;
    logic              out_tvalid;
    logic              out_tlast;
    ssb_pkg::sym_idx_t out_tuser;
    logic              pbch_valid;
    logic              sss_valid;
    logic              overflow;

    int   err_count;
    int   tests_failed;
    int   test_num;
    int   cycle_count;
    int   out_count;
    int   stall_mode;
    int   stall_phase;
    logic check_en;
    logic gaps_on;
    logic model_on;

`include "tb_ssb_model.svh"

    ssb_sync_top #(
        .PSS_LEN          (PSS_LEN),
        .PSS_TAPS         (PSS_TAPS),
        .DETECT_THRESHOLD (DETECT_THRESHOLD),
        .FFT_LEN          (FFT_LEN),
        .CP_LEN           (CP_LEN),
        .FIFO_DEPTH       (FIFO_DEPTH)
    ) DUT (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .s_axis_in_tdata_i   (in_tdata),
        .s_axis_in_tvalid_i  (in_tvalid),
        .m_axis_out_tready_i (out_tready),
        .m_axis_out_tdata_o  (out_tdata),
        .m_axis_out_tvalid_o (out_tvalid),
        .m_axis_out_tlast_o  (out_tlast),
        .m_axis_out_tuser_o  (out_tuser),
        .pbch_valid_o        (pbch_valid),
        .sss_valid_o         (sss_valid),
        .overflow_o          (overflow)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // ************************************************************
    // output monitor.
    // ************************************************************

    always @(posedge clk_i) begin
        beat_t exp_b;
        if (!rst_i && out_tvalid && out_tready) begin
            out_count++;
            if (check_en) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected output beat at %0t, model expects none", $time);
                    err_count++;
                end else begin
                    exp_b = exp_q.pop_front();
                    check_value(out_tdata, exp_b.data, "tdata");
                    check_value(out_tlast, exp_b.last, "tlast");
                    check_value(out_tuser, exp_b.sym, "tuser");
                    check_value(pbch_valid, exp_b.pbch, "pbch_valid");
                    check_value(sss_valid, exp_b.sss, "sss_valid");
                end
            end
        end
    end

    // ************************************************************
    // stimulus.
    // ************************************************************

    // all inputs change on the falling edge.
    task automatic drive_cycle(input logic valid, input ssb_pkg::sample_t data);
        @(negedge clk_i);
        in_tvalid = valid;
        in_tdata  = data;
        case (stall_mode)
            0: out_tready = 1'b1;
            1: out_tready = !((stall_phase < 2) && ($urandom_range(1, 0) == 1));
            default: out_tready = 1'b0;
        endcase
        stall_phase = (stall_phase + 1) % 8;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0);
    endtask

    task automatic send_sample(input ssb_pkg::sample_t s);
        while (gaps_on && $urandom_range(4, 0) == 0) begin
            drive_cycle(1'b0, '0);
        end
        drive_cycle(1'b1, s);
        if (model_on) begin
            model_step(s);
        end
    endtask

    // noise stays within +-4, symbol data within +-32.
    task automatic send_noise(input int n);
        logic [7:0] re;
        logic [7:0] im;
        repeat (n) begin
            re = 8'($urandom_range(8, 0)) - 8'd4;
            im = 8'($urandom_range(8, 0)) - 8'd4;
            send_sample({re, im});
        end
    endtask

    task automatic send_data(input int n);
        logic [7:0] re;
        logic [7:0] im;
        repeat (n) begin
            re = 8'($urandom_range(63, 0)) - 8'd32;
            im = 8'($urandom_range(63, 0)) - 8'd32;
            send_sample({re, im});
        end
    endtask

    task automatic send_pss();
        logic [7:0] a;
        for (int i = 0; i < PSS_LEN; i++) begin
            a = PSS_TAPS[i] ? 8'(PSS_AMP) : 8'(-PSS_AMP);
            send_sample({a, a});
        end
    endtask

    task automatic send_ssb();
        send_pss();
        send_data(3 * (CP_LEN + FFT_LEN));
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            drive_cycle(1'b0, '0);
        end
        idle(FLUSH_CYCLES);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_num++;
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_num, name, err_count - errs_before);
        end
    endtask

    initial begin
        int errs;
        int beats;
        rst_i       = 1'b1;
        in_tdata    = '0;
        in_tvalid   = 1'b0;
        out_tready  = 1'b1;
        err_count   = 0;
        tests_failed = 0;
        test_num    = 0;
        cycle_count = 0;
        out_count   = 0;
        stall_mode  = 0;
        stall_phase = 0;
        check_en    = 1'b1;
        gaps_on     = 1'b0;
        model_on    = 1'b1;
        void'($urandom(SEED));
        model_reset();
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        errs = err_count;
        idle(3);
        check_value(out_tvalid, 1'b0, "tvalid after reset");
        check_value(out_tlast, 1'b0, "tlast after reset");
        check_value(pbch_valid, 1'b0, "pbch_valid after reset");
        check_value(sss_valid, 1'b0, "sss_valid after reset");
        check_value(overflow, 1'b0, "overflow after reset");
        finish_test("reset state", errs);

        errs  = err_count;
        beats = out_count;
        send_noise(20);
        send_ssb();
        drain();
        check_value(out_count - beats, 3 * FFT_LEN, "beat count");
        finish_test("single ssb", errs);

        errs  = err_count;
        beats = out_count;
        send_noise(200);
        drain();
        check_value(out_count - beats, 0, "beat count");
        finish_test("noise only", errs);

        errs    = err_count;
        beats   = out_count;
        gaps_on = 1'b1;
        stall_mode = 1;
        repeat (2) begin
            send_noise(10);
            send_ssb();
        end
        drain();
        gaps_on    = 1'b0;
        stall_mode = 0;
        check_value(out_count - beats, 6 * FFT_LEN, "beat count");
        check_value(overflow, 1'b0, "overflow");
        finish_test("stalls and gaps", errs);

        // pss copy forms the whole body of symbol 1.
        errs  = err_count;
        beats = out_count;
        send_pss();
        send_data(CP_LEN);
        send_pss();
        send_data(2 * (CP_LEN + FFT_LEN));
        send_noise(10);
        send_ssb();
        drain();
        check_value(out_count - beats, 6 * FFT_LEN, "beat count");
        finish_test("inner pss", errs);

        errs       = err_count;
        model_on   = 1'b0;
        check_en   = 1'b0;
        stall_mode = 2;
        send_noise(5);
        send_pss();
        send_data(3 * FIFO_DEPTH);
        idle(FLUSH_CYCLES);
        check_value(overflow, 1'b1, "overflow while stalled");
        stall_mode = 0;
        idle(4 * FIFO_DEPTH);
        check_value(overflow, 1'b1, "overflow after stall");
        finish_test("overflow", errs);

        $display("summary: %0d tests, %0d failed, %0d mismatches",
                 test_num, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+tests
source/ssb_pkg.sv
source/smp_if.sv
source/pss_correlator.sv
source/sample_fifo.sv
source/ssb_extractor.sv
source/ssb_sync_top.sv
tests/tb_ssb_sync.sv

// File: run_sim.sh
#!/bin/sh
# build the ssb testbench with verilator, run it, then search the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_ssb_sync -Mdir obj_dir -o tb_ssb_sync > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_ssb_sync > sim.log 2>&1 ; cat sim.log

grep -q "TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
